// ==== Bender.yml ====
package:
  name: audio_fir

sources:
  # packages first, then datapath and control, then the top level
  - common/audio_pkg.sv
  - common/fir_pkg.sv
  - fir/fir_sequencer.sv
  - fir/sample_history.sv
  - fir/coeff_table.sv
  - fir/mac_unit.sv
  - fir/output_scaler.sv
  - rtl/audio_fir_top.sv
  - target: test
    files:
      - dv/audio_fir_tb.sv

// ==== common/audio_pkg.sv ====
package audio_pkg;

    // ==============================
    // sample format
    // ==============================

    localparam int SAMPLE_WIDTH = 16;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t; // mono pcm, two's complement

    // ==============================
    // output limits
    // ==============================

    // clamp range applied after gain scaling
    localparam sample_t SAMPLE_MAX = 32767;
    localparam sample_t SAMPLE_MIN = -32768;

endpackage

// ==== common/fir_pkg.sv ====
package fir_pkg;

    // ==============================
    // filter structure
    // ==============================

    localparam int TAP_COUNT     = 29;
    localparam int TAP_IDX_WIDTH = 5;  // enough to count 0..28
    localparam int COEF_WIDTH    = 9;  // peak tap is 128, needs sign bit
    localparam int ACC_WIDTH     = 32;
    localparam int GAIN_SHIFT    = 10; // table dc gain is 1024

    typedef logic [TAP_IDX_WIDTH-1:0]     tap_idx_t;
    typedef logic signed [COEF_WIDTH-1:0] coef_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // half an output lsb, added before the shift
    localparam acc_t ROUND_BIAS = acc_t'(1) <<< (GAIN_SHIFT - 1);

    // ==============================
    // coefficient table
    // ==============================

    // symmetric low-pass, centre tap 14, taps sum to 1024
    localparam coef_t COEFFS [0:TAP_COUNT-1] = '{
        -1,  -2,  -3,  -5,  -6,  -5,   0,  10,
        25,  45,  67,  90, 110, 123, 128, 123,
        110, 90,  67,  45,  25,  10,   0,  -5,
        -6,  -5,  -3,  -2,  -1
    };

    // ==============================
    // sequencer states
    // ==============================

    typedef enum logic [1:0] {
        IDLE,  // waiting for a sample strobe
        RUN,   // one tap per cycle
        DRAIN, // let the read and mac pipeline empty
        DONE   // hand the sum to the scaler
    } fir_state_t;

endpackage

// ==== dv/audio_fir_tb.sv ====
`timescale 1ns/1ps

module audio_fir_tb;

    // acceptance edge to out_valid spans the run, two drain cycles and done
    localparam int OUT_LATENCY = fir_pkg::TAP_COUNT + 3;
    localparam int IMPULSE_LEN = fir_pkg::TAP_COUNT + 6;
    localparam int DC_LEN      = fir_pkg::TAP_COUNT + 6;
    localparam int RANDOM_LEN  = 200;
    localparam int SAT_LEN     = 2 * fir_pkg::TAP_COUNT;
    localparam int BUSY_LEN    = 5;
    localparam int NUM_SAMPLES = 2 * IMPULSE_LEN + DC_LEN + RANDOM_LEN + SAT_LEN + BUSY_LEN + 1;
    localparam int WATCHDOG_CYCLES = NUM_SAMPLES * 40 + 200;

    logic               clk_in;
    logic               rst_in;
    audio_pkg::sample_t sample_in;
    logic               sample_valid;
    audio_pkg::sample_t filtered_out;
    logic               out_valid;
    logic               busy;

    int                 cycle = 0;
    int                 error_count = 0;
    int                 out_count = 0;
    int                 sent_count = 0;
    int                 seed = 65115;
    int                 exp_c;
    audio_pkg::sample_t exp_v;
    audio_pkg::sample_t last_out;
    audio_pkg::sample_t hist_q [$];  // newest at the front
    audio_pkg::sample_t exp_val_q [$];
    int                 exp_cyc_q [$];

    audio_fir_top DUT (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .filtered_out (filtered_out),
        .out_valid    (out_valid),
        .busy         (busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in) cycle <= cycle + 1;

    // ==============================
    // reference model
    // ==============================

    function automatic audio_pkg::sample_t ref_output();
        longint sum;
        sum = 0;
        for (int k = 0; k < fir_pkg::TAP_COUNT; k++) begin
            sum += longint'(hist_q[k]) * longint'(fir_pkg::COEFFS[k]);
        end
        sum = (sum + (longint'(1) <<< (fir_pkg::GAIN_SHIFT - 1))) >>> fir_pkg::GAIN_SHIFT;
        if (sum > longint'(audio_pkg::SAMPLE_MAX)) return audio_pkg::SAMPLE_MAX;
        if (sum < longint'(audio_pkg::SAMPLE_MIN)) return audio_pkg::SAMPLE_MIN;
        return audio_pkg::sample_t'(sum);
    endfunction

    task automatic reset_model();
        hist_q.delete();
        exp_val_q.delete();
        exp_cyc_q.delete();
        for (int k = 0; k < fir_pkg::TAP_COUNT; k++) hist_q.push_back('0);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error: %s got %0h expected %0h at cycle %0d", name, got, expected, cycle);
            error_count++;
        end
    endtask

    // ==============================
    // stimulus
    // ==============================

    // one-cycle strobe that reports the edge which samples it
    task automatic drive_strobe(input audio_pkg::sample_t s, output int accept_cycle);
        @(posedge clk_in);
        #1;
        sample_in    = s;
        sample_valid = 1'b1;
        accept_cycle = cycle + 1;
        @(posedge clk_in);
        #1;
        sample_valid = 1'b0;
        sample_in    = '0;
    endtask

    task automatic issue_sample(input audio_pkg::sample_t s);
        int acc_c;
        drive_strobe(s, acc_c);
        hist_q.push_front(s);
        void'(hist_q.pop_back());
        exp_val_q.push_back(ref_output());
        exp_cyc_q.push_back(acc_c + OUT_LATENCY);
        sent_count++;
        @(negedge clk_in);
        check_value("busy", busy, 1);
    endtask

    task automatic send_sample(input audio_pkg::sample_t s);
        issue_sample(s);
        wait (out_count == sent_count);
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        #1 rst_in = 1'b1;
        repeat (4) @(posedge clk_in);
        #1 rst_in = 1'b0;
        @(negedge clk_in);
        check_value("out_valid", out_valid, 0);
        check_value("busy", busy, 0);
        check_value("filtered_out", filtered_out, 0);
    endtask

    task automatic run_impulse();
        audio_pkg::sample_t expect_s;
        for (int i = 0; i < IMPULSE_LEN; i++) begin
            send_sample((i == 0) ? audio_pkg::sample_t'(1024) : audio_pkg::sample_t'(0));
            if (i < fir_pkg::TAP_COUNT) expect_s = fir_pkg::COEFFS[i];
            else expect_s = '0;
            check_value("filtered_out", last_out, expect_s);
        end
    endtask

    // ==============================
    // compare and watchdog
    // ==============================

    always @(negedge clk_in) begin
        if (!rst_in && out_valid) begin
            if (exp_val_q.size() == 0) begin
                $display("out_valid rose at cycle %0d with no accepted sample pending", cycle);
                error_count++;
            end else begin
                exp_v = exp_val_q.pop_front();
                exp_c = exp_cyc_q.pop_front();
                check_value("filtered_out", filtered_out, exp_v);
                check_value("out_valid cycle", cycle, exp_c);
            end
            check_value("busy", busy, 0); // idle again when the result appears
            last_out = filtered_out;
            out_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
        $display("errors: %0d, outputs seen: %0d", error_count, out_count);
        $display("test failed");
        $finish;
    end

    // ==============================
    // test sequence
    // ==============================

    initial begin
        audio_pkg::sample_t s;
        int                 dummy;
        rst_in       = 1'b1;
        sample_valid = 1'b0;
        sample_in    = '0;
        reset_model();
        apply_reset();

        run_impulse();

        for (int i = 0; i < DC_LEN; i++) begin
            send_sample(audio_pkg::sample_t'(1000));
            if (i >= fir_pkg::TAP_COUNT - 1) check_value("filtered_out", last_out, 1000);
        end

        for (int i = 0; i < RANDOM_LEN; i++) begin
            send_sample(audio_pkg::sample_t'($random(seed)));
        end

        // signs follow the taps and go oldest first so tap 0 meets the newest
        for (int k = fir_pkg::TAP_COUNT - 1; k >= 0; k--) begin
            if (fir_pkg::COEFFS[k] >= 0) s = audio_pkg::SAMPLE_MAX;
            else s = audio_pkg::SAMPLE_MIN;
            send_sample(s);
        end
        check_value("filtered_out", last_out, audio_pkg::SAMPLE_MAX);
        for (int k = fir_pkg::TAP_COUNT - 1; k >= 0; k--) begin
            if (fir_pkg::COEFFS[k] >= 0) s = audio_pkg::SAMPLE_MIN;
            else s = audio_pkg::SAMPLE_MAX;
            send_sample(s);
        end
        check_value("filtered_out", last_out, audio_pkg::SAMPLE_MIN);

        // strobe during the tap walk must be dropped
        issue_sample(audio_pkg::sample_t'(12345));
        repeat (8) @(posedge clk_in);
        check_value("busy", busy, 1);
        drive_strobe(audio_pkg::sample_t'(32000), dummy);
        wait (out_count == sent_count);
        send_sample(audio_pkg::sample_t'(-2000));
        send_sample('0);
        send_sample('0);

        // reset in the middle of a walk
        drive_strobe(audio_pkg::sample_t'(30000), dummy);
        repeat (12) @(posedge clk_in);
        reset_model();
        apply_reset();
        run_impulse();

        repeat (5) @(posedge clk_in);
        if (exp_val_q.size() != 0) begin
            $display("%0d expected outputs never arrived", exp_val_q.size());
            error_count++;
        end
        $display("errors: %0d, outputs checked: %0d", error_count, out_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== fir/coeff_table.sv ====
`timescale 1ns/1ps

module coeff_table (
    input  logic              clk_in,
    input  fir_pkg::tap_idx_t tap_idx,
    output fir_pkg::coef_t    coef
);

    // registered rom, one cycle latency like the history read
    always_ff @(posedge clk_in) begin
        if (tap_idx < fir_pkg::tap_idx_t'(fir_pkg::TAP_COUNT)) begin
            coef <= fir_pkg::COEFFS[tap_idx];
        end else begin
            coef <= '0; // unused index codes
        end
    end

endmodule

// ==== fir/fir_sequencer.sv ====
`timescale 1ns/1ps

module fir_sequencer (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             sample_valid,
    output logic             hist_write,
    output logic             acc_clear,
    output logic             tap_en,
    output logic             mac_en,
    output logic             scale_en,
    output logic             busy,
    output fir_pkg::tap_idx_t tap_idx
);

    fir_pkg::fir_state_t state;
    logic                drain_cnt; // two drain cycles
    logic                accept;

    assign accept = (state == fir_pkg::IDLE) && sample_valid; // strobes while busy are dropped

    assign hist_write = accept;
    assign acc_clear  = accept;
    assign tap_en     = (state == fir_pkg::RUN);
    assign scale_en   = (state == fir_pkg::DONE);
    assign busy       = (state != fir_pkg::IDLE);

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= fir_pkg::IDLE;
            tap_idx   <= '0;
            drain_cnt <= 1'b0;
        end else begin
            case (state)
                fir_pkg::IDLE: begin
                    if (accept) begin
                        state   <= fir_pkg::RUN;
                        tap_idx <= '0;
                    end
                end
                fir_pkg::RUN: begin
                    if (tap_idx == fir_pkg::tap_idx_t'(fir_pkg::TAP_COUNT - 1)) begin
                        state     <= fir_pkg::DRAIN;
                        drain_cnt <= 1'b0;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                fir_pkg::DRAIN: begin
                    if (drain_cnt) state <= fir_pkg::DONE;
                    drain_cnt <= 1'b1;
                end
                fir_pkg::DONE: begin
                    state <= fir_pkg::IDLE; // next sample may land with out_valid
                end
                default: state <= fir_pkg::IDLE;
            endcase
        end
    end

    // mac adds once history and coeff reads have settled
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            mac_en <= 1'b0;
        end else begin
            mac_en <= tap_en;
        end
    end

endmodule

// ==== fir/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               clear,
    input  logic               en,
    input  audio_pkg::sample_t tap_sample,
    input  fir_pkg::coef_t     coef,
    output fir_pkg::acc_t      acc
);

    fir_pkg::acc_t product;

    // single signed multiplier, both operands sign extended
    assign product = fir_pkg::acc_t'(tap_sample) * fir_pkg::acc_t'(coef);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;  // new sample, fresh sum
        end else if (en) begin
            acc <= acc + product;
        end
    end

endmodule

// ==== fir/output_scaler.sv ====
`timescale 1ns/1ps

module output_scaler (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               en,
    input  fir_pkg::acc_t      acc,
    output audio_pkg::sample_t filtered_out,
    output logic               out_valid
);

    fir_pkg::acc_t rounded;
    fir_pkg::acc_t shifted;

    // round half up, then drop the table gain
    assign rounded = acc + fir_pkg::ROUND_BIAS;
    assign shifted = rounded >>> fir_pkg::GAIN_SHIFT;

    // ==============================
    // saturate and register
    // ==============================

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            filtered_out <= '0;
            out_valid    <= 1'b0;
        end else begin
            out_valid <= en; // one-cycle strobe
            if (en) begin
                if (shifted > fir_pkg::acc_t'(audio_pkg::SAMPLE_MAX)) begin
                    filtered_out <= audio_pkg::SAMPLE_MAX;
                end else if (shifted < fir_pkg::acc_t'(audio_pkg::SAMPLE_MIN)) begin
                    filtered_out <= audio_pkg::SAMPLE_MIN;
                end else begin
                    filtered_out <= audio_pkg::sample_t'(shifted);
                end
            end
        end
    end

endmodule

// ==== fir/sample_history.sv ====
`timescale 1ns/1ps

module sample_history (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               write,
    input  audio_pkg::sample_t sample_in,
    input  fir_pkg::tap_idx_t  tap_idx,
    output audio_pkg::sample_t tap_sample
);

    audio_pkg::sample_t mem [0:fir_pkg::TAP_COUNT-1];
    fir_pkg::tap_idx_t  wr_ptr;  // next slot to fill
    logic [5:0]         rd_sum;  // wr_ptr - 1 - tap_idx, before wrap
    fir_pkg::tap_idx_t  rd_addr;

    // newest entry sits just behind wr_ptr
    assign rd_sum  = 6'(wr_ptr) + 6'(fir_pkg::TAP_COUNT - 1) - 6'(tap_idx);
    assign rd_addr = (rd_sum >= 6'(fir_pkg::TAP_COUNT)) ?
                     fir_pkg::tap_idx_t'(rd_sum - 6'(fir_pkg::TAP_COUNT)) :
                     fir_pkg::tap_idx_t'(rd_sum);

    // ==============================
    // write side
    // ==============================

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            for (int i = 0; i < fir_pkg::TAP_COUNT; i++) begin
                mem[i] <= '0; // start from silence
            end
        end else if (write) begin
            mem[wr_ptr] <= sample_in;
            if (wr_ptr == fir_pkg::tap_idx_t'(fir_pkg::TAP_COUNT - 1)) wr_ptr <= '0;
            else wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // registered read, one cycle behind tap_idx
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tap_sample <= '0;
        end else begin
            tap_sample <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/audio_fir_top.sv ====
`timescale 1ns/1ps

module audio_fir_top (
    input  logic               clk_in,
    input  logic               rst_in,
    input  audio_pkg::sample_t sample_in,
    input  logic               sample_valid,
    output audio_pkg::sample_t filtered_out,
    output logic               out_valid,
    output logic               busy
);

    logic               hist_write;
    logic               acc_clear;
    logic               tap_en;
    logic               mac_en;
    logic               scale_en;
    fir_pkg::tap_idx_t  tap_idx;
    audio_pkg::sample_t tap_sample;
    fir_pkg::coef_t     coef;
    fir_pkg::acc_t      acc;

    // ==============================
    // control
    // ==============================

    fir_sequencer u_seq (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .hist_write   (hist_write),
        .acc_clear    (acc_clear),
        .tap_en       (tap_en),
        .mac_en       (mac_en),
        .scale_en     (scale_en),
        .busy         (busy),
        .tap_idx      (tap_idx)
    );

    // ==============================
    // datapath
    // ==============================

    sample_history u_hist (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .write      (hist_write),
        .sample_in  (sample_in),
        .tap_idx    (tap_idx),
        .tap_sample (tap_sample)
    );

    coeff_table u_coef (
        .clk_in  (clk_in),
        .tap_idx (tap_idx),
        .coef    (coef)
    );

    mac_unit u_mac (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .clear      (acc_clear),
        .en         (mac_en),      // tap_en delayed to match read latency
        .tap_sample (tap_sample),
        .coef       (coef),
        .acc        (acc)
    );

    output_scaler u_scale (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .en           (scale_en),
        .acc          (acc),
        .filtered_out (filtered_out),
        .out_valid    (out_valid)
    );

endmodule

// ==== sources.f ====
common/audio_pkg.sv
common/fir_pkg.sv
fir/fir_sequencer.sv
fir/sample_history.sv
fir/coeff_table.sv
fir/mac_unit.sv
fir/output_scaler.sv
rtl/audio_fir_top.sv
dv/audio_fir_tb.sv
